// File: include/rv32_settings.svh
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// Ingress queue depth, equal to the sender's credits after reset.
`define INGRESS_DEPTH 4

// Data memory size in 32-bit words.
`define DMEM_WORDS 256

// Cycles from request capture to response.
`define DMEM_LATENCY 2

`endif

// File: source/rv32i_types.sv
package rv32i_types;

    typedef enum logic [2:0] {
        lb_mem  = 3'b000,
        lbu_mem = 3'b001,
        lh_mem  = 3'b010,
        lhu_mem = 3'b011,
        lw_mem  = 3'b100
    } load_ops_t;

    typedef enum logic [1:0] {
        sb_mem = 2'b00,
        sh_mem = 2'b01,
        sw_mem = 2'b10
    } store_ops_t;

    typedef enum logic [3:0] {
        alu_out_wb  = 4'd0,
        br_en_wb    = 4'd1,
        u_imm_wb    = 4'd2,
        lb_wb       = 4'd3,
        lbu_wb      = 4'd4,
        lh_wb       = 4'd5,
        lhu_wb      = 4'd6,
        lw_wb       = 4'd7,
        pc_plus4_wb = 4'd8
    } regf_m_sel_t;

    typedef struct packed {
        logic       MemRead;
        logic       MemWrite;
        load_ops_t  load_ops;
        store_ops_t store_ops;
    } mem_signal_t;

    typedef struct packed {
        logic        regf_we;
        regf_m_sel_t regf_m_sel;
    } wb_signal_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd_s;
        logic [31:0] alu_out;
        logic [31:0] br_en;
        logic [31:0] u_imm;
        logic [31:0] rs2_v;
        mem_signal_t mem_signal;
        wb_signal_t  wb_signal;
    } ex_mem_stage_reg_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd_s;
        logic [31:0] alu_out;
        logic [31:0] br_en;
        logic [31:0] u_imm;
        logic [31:0] rs2_v;
        mem_signal_t mem_signal;
        wb_signal_t  wb_signal;
        logic [31:0] mem_addr;
    } mem_wb_stage_reg_t;

    // Word address, lane-aligned write data.
    typedef struct packed {
        logic [29:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } dmem_req_t;

endpackage

// File: source/ingress_fifo.sv
`include "rv32_settings.svh"

module ingress_fifo
import rv32i_types::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  ex_mem_stage_reg_t din,
    input  logic              pop,
    output ex_mem_stage_reg_t head,
    output logic              head_valid,
    output logic              credit_return
);

    localparam int DEPTH = `INGRESS_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ex_mem_stage_reg_t  entries [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;

    assign full          = (count == CNT_W'(DEPTH));
    assign head          = entries[rd_ptr];
    assign head_valid    = (count != '0);
    // One credit goes back to the sender per entry freed.
    assign credit_return = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The sender pushed without holding a credit.
    push_while_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("ingress_fifo: push while full, credit violation");

endmodule

// File: source/mem_stage.sv
module mem_stage
import rv32i_types::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  ex_mem_stage_reg_t head,
    input  logic              head_valid,
    output logic              pop,
    input  logic              wb_commit,
    output dmem_req_t         dmem_req,
    output logic              dmem_req_valid,
    output mem_wb_stage_reg_t mem_wb_stage_reg
);

    logic head_is_mem;
    logic [1:0] lane;

    assign head_is_mem = head.mem_signal.MemRead | head.mem_signal.MemWrite;
    assign lane        = head.alu_out[1:0];

    // Advance when the register is empty or its record retires this cycle.
    assign pop            = head_valid & (~mem_wb_stage_reg.valid | wb_commit);
    assign dmem_req_valid = pop & head_is_mem;

    always_comb begin
        dmem_req.addr  = head.alu_out[31:2];
        dmem_req.rmask = '0;
        dmem_req.wmask = '0;
        dmem_req.wdata = head.rs2_v << {lane, 3'b000};
        if (head.mem_signal.MemRead) begin
            case (head.mem_signal.load_ops)
                lb_mem, lbu_mem: dmem_req.rmask = 4'b0001 << lane;
                lh_mem, lhu_mem: dmem_req.rmask = 4'b0011 << lane;
                lw_mem:          dmem_req.rmask = 4'b1111;
                default:         dmem_req.rmask = '0;
            endcase
        end else if (head.mem_signal.MemWrite) begin
            case (head.mem_signal.store_ops)
                sb_mem:  dmem_req.wmask = 4'b0001 << lane;
                sh_mem:  dmem_req.wmask = 4'b0011 << lane;
                sw_mem:  dmem_req.wmask = 4'b1111;
                default: dmem_req.wmask = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_stage_reg <= '0;
        end else if (pop) begin
            mem_wb_stage_reg.valid      <= head.valid;
            mem_wb_stage_reg.pc         <= head.pc;
            mem_wb_stage_reg.rd_s       <= head.rd_s;
            mem_wb_stage_reg.alu_out    <= head.alu_out;
            mem_wb_stage_reg.br_en      <= head.br_en;
            mem_wb_stage_reg.u_imm      <= head.u_imm;
            mem_wb_stage_reg.rs2_v      <= head.rs2_v;
            mem_wb_stage_reg.mem_signal <= head.mem_signal;
            mem_wb_stage_reg.wb_signal  <= head.wb_signal;
            mem_wb_stage_reg.mem_addr   <= head.alu_out;
        end else if (wb_commit) begin
            mem_wb_stage_reg.valid <= 1'b0;
        end
    end

endmodule

// File: source/dmem_sram.sv
`include "rv32_settings.svh"

module dmem_sram
import rv32i_types::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  dmem_req_t   dmem_req,
    input  logic        dmem_req_valid,
    output logic        dmem_resp,
    output logic [31:0] dmem_rdata
);

    localparam int WORDS   = `DMEM_WORDS;
    localparam int LATENCY = `DMEM_LATENCY;
    localparam int IDX_W   = $clog2(WORDS);

    logic [31:0]      mem [WORDS];
    logic [IDX_W-1:0] idx;
    logic             resp_pipe [LATENCY];
    logic [31:0]      data_pipe [LATENCY];

    assign idx = dmem_req.addr[IDX_W-1:0];

    // Byte-masked write and array read both happen at capture.
    always_ff @(posedge clk) begin
        if (dmem_req_valid) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.wmask[b]) begin
                    mem[idx][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
                end
            end
        end
        data_pipe[0] <= mem[idx];
        for (int i = 1; i < LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LATENCY; i++) begin
                resp_pipe[i] <= 1'b0;
            end
        end else begin
            resp_pipe[0] <= dmem_req_valid;
            for (int i = 1; i < LATENCY; i++) begin
                resp_pipe[i] <= resp_pipe[i-1];
            end
        end
    end

    assign dmem_resp  = resp_pipe[LATENCY-1];
    assign dmem_rdata = data_pipe[LATENCY-1];

    mask_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_valid |-> !(|dmem_req.rmask && |dmem_req.wmask))
        else $error("dmem_sram: request with both read and write masks set");

endmodule

// File: source/wb_stage.sv
module wb_stage
import rv32i_types::*;
(
    input  mem_wb_stage_reg_t mem_wb_stage_reg,
    input  logic              dmem_resp,
    input  logic [31:0]       dmem_rdata,
    output logic              wb_commit,
    output logic [4:0]        wb_rd_s,
    output logic [31:0]       wb_rd_v,
    output logic              wb_regf_we
);

    mem_signal_t mem_signal;
    wb_signal_t  wb_signal;
    logic [1:0]  lane;
    logic [7:0]  byte_v;
    logic [15:0] half_v;
    logic        is_mem;

    assign mem_signal = mem_wb_stage_reg.mem_signal;
    assign wb_signal  = mem_wb_stage_reg.wb_signal;
    assign lane       = mem_wb_stage_reg.mem_addr[1:0];
    assign is_mem     = mem_signal.MemRead | mem_signal.MemWrite;

    // Lane picked by the low address bits.
    assign byte_v = dmem_rdata[8*lane +: 8];
    assign half_v = dmem_rdata[16*lane[1] +: 16];

    always_comb begin
        case (wb_signal.regf_m_sel)
            alu_out_wb:  wb_rd_v = mem_wb_stage_reg.alu_out;
            br_en_wb:    wb_rd_v = mem_wb_stage_reg.br_en;
            u_imm_wb:    wb_rd_v = mem_wb_stage_reg.u_imm;
            lb_wb:       wb_rd_v = {{24{byte_v[7]}}, byte_v};
            lbu_wb:      wb_rd_v = {24'b0, byte_v};
            lh_wb:       wb_rd_v = {{16{half_v[15]}}, half_v};
            lhu_wb:      wb_rd_v = {16'b0, half_v};
            lw_wb:       wb_rd_v = dmem_rdata;
            pc_plus4_wb: wb_rd_v = mem_wb_stage_reg.pc + 32'd4;
            default:     wb_rd_v = '0;
        endcase
    end

    // Memory records wait for the response, everything else retires at once.
    assign wb_commit = mem_wb_stage_reg.valid & (~is_mem | dmem_resp);

    // Stores never target a register.
    assign wb_rd_s    = mem_signal.MemWrite ? 5'd0 : mem_wb_stage_reg.rd_s;
    assign wb_regf_we = wb_commit & wb_signal.regf_we;

endmodule

// File: source/regfile.sv
module regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  wb_rd_s,
    input  logic [31:0] wb_rd_v,
    input  logic        wb_regf_we,
    input  logic [4:0]  rs_s,
    output logic [31:0] rs_v
);

    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_regf_we && wb_rd_s != 5'd0) begin
            regs[wb_rd_s] <= wb_rd_v;
        end
    end

    // x0 has no storage.
    assign rs_v = (rs_s == 5'd0) ? 32'd0 : regs[rs_s];

endmodule

// File: source/mem_wb_top.sv
module mem_wb_top
import rv32i_types::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid,
    input  ex_mem_stage_reg_t ex_in,
    output logic              credit_return,
    input  logic [4:0]        rs_s,
    output logic [31:0]       rs_v,
    output logic              wb_commit
);

    ex_mem_stage_reg_t head;
    logic              head_valid;
    logic              pop;
    dmem_req_t         dmem_req;
    logic              dmem_req_valid;
    logic              dmem_resp;
    logic [31:0]       dmem_rdata;
    mem_wb_stage_reg_t mem_wb_stage_reg;
    logic [4:0]        wb_rd_s;
    logic [31:0]       wb_rd_v;
    logic              wb_regf_we;

    ingress_fifo u_ingress_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (ex_valid),
        .din           (ex_in),
        .pop           (pop),
        .head          (head),
        .head_valid    (head_valid),
        .credit_return (credit_return)
    );

    mem_stage u_mem_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .head             (head),
        .head_valid       (head_valid),
        .pop              (pop),
        .wb_commit        (wb_commit),
        .dmem_req         (dmem_req),
        .dmem_req_valid   (dmem_req_valid),
        .mem_wb_stage_reg (mem_wb_stage_reg)
    );

    dmem_sram u_dmem_sram (
        .clk            (clk),
        .rst_n          (rst_n),
        .dmem_req       (dmem_req),
        .dmem_req_valid (dmem_req_valid),
        .dmem_resp      (dmem_resp),
        .dmem_rdata     (dmem_rdata)
    );

    wb_stage u_wb_stage (
        .mem_wb_stage_reg (mem_wb_stage_reg),
        .dmem_resp        (dmem_resp),
        .dmem_rdata       (dmem_rdata),
        .wb_commit        (wb_commit),
        .wb_rd_s          (wb_rd_s),
        .wb_rd_v          (wb_rd_v),
        .wb_regf_we       (wb_regf_we)
    );

    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_rd_s    (wb_rd_s),
        .wb_rd_v    (wb_rd_v),
        .wb_regf_we (wb_regf_we),
        .rs_s       (rs_s),
        .rs_v       (rs_v)
    );

endmodule

// File: dv/tb_mem_wb_top.sv
`include "rv32_settings.svh"

module tb_mem_wb_top import rv32i_types::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEND_LIMIT  = 20000;
    localparam int DRAIN_LIMIT = 2000;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              ex_valid;
    ex_mem_stage_reg_t ex_in;
    logic              credit_return;
    logic [4:0]        rs_s;
    logic [31:0]       rs_v;
    logic              wb_commit;

    logic [31:0]       lfsr = 32'he11f;
    logic [31:0]       shadow_mem [`DMEM_WORDS];
    logic [31:0]       shadow_regs [32] = '{default: '0};
    ex_mem_stage_reg_t stim [$];
    int                ret_total  = 0;
    int                commits    = 0;
    int                mismatches = 0;
    int                failures   = 0;

    mem_wb_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_valid      (ex_valid),
        .ex_in         (ex_in),
        .credit_return (credit_return),
        .rs_s          (rs_s),
        .rs_v          (rs_v),
        .wb_commit     (wb_commit)
    );

    always #50 clk = ~clk;

    // Galois LFSR, one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Kinds 0 to 3 are ALU-side results, 4 a store, 5 and 6 any load, 7 a word load.
    function automatic ex_mem_stage_reg_t make_record(input int kind);
        ex_mem_stage_reg_t r;
        logic [2:0]        op;
        logic [1:0]        lane;
        r = '0;
        r.valid = 1'b1;
        r.pc = rand_bits(30) << 2;
        r.rd_s = 5'(rand_bits(5));
        r.alu_out = rand_bits(32);
        r.br_en = rand_bits(1);
        r.u_imm = rand_bits(20) << 12;
        r.rs2_v = rand_bits(32);
        r.wb_signal.regf_we = 1'b1;
        lane = 2'(rand_bits(2));
        case (kind)
            0: r.wb_signal.regf_m_sel = alu_out_wb;
            1: r.wb_signal.regf_m_sel = br_en_wb;
            2: r.wb_signal.regf_m_sel = u_imm_wb;
            3: r.wb_signal.regf_m_sel = pc_plus4_wb;
            4: begin
                op = 3'(rand_bits(2));
                if (op == 3'd3) begin
                    op = 3'd2;
                end
                r.mem_signal.MemWrite = 1'b1;
                r.mem_signal.store_ops = store_ops_t'(op[1:0]);
                r.wb_signal.regf_we = 1'b0;
                if (op == 3'd1) begin
                    lane[0] = 1'b0;
                end else if (op == 3'd2) begin
                    lane = 2'd0;
                end
            end
            default: begin
                op = (kind == 7) ? 3'd4 : 3'(rand_bits(3) % 5);
                r.mem_signal.MemRead = 1'b1;
                r.mem_signal.load_ops = load_ops_t'(op);
                case (op)
                    3'd0:    r.wb_signal.regf_m_sel = lb_wb;
                    3'd1:    r.wb_signal.regf_m_sel = lbu_wb;
                    3'd2:    r.wb_signal.regf_m_sel = lh_wb;
                    3'd3:    r.wb_signal.regf_m_sel = lhu_wb;
                    default: r.wb_signal.regf_m_sel = lw_wb;
                endcase
                if (op >= 3'd4) begin
                    lane = 2'd0;
                end else if (op >= 3'd2) begin
                    lane[0] = 1'b0;
                end
            end
        endcase
        if (kind >= 4) begin
            r.alu_out = {26'b0, 4'(rand_bits(4)), lane};
        end
        return r;
    endfunction

    // Reference model, applied in send order.
    function automatic void predict_record(input ex_mem_stage_reg_t r);
        int          idx;
        int          shift;
        logic [31:0] word;
        logic [31:0] value;
        logic [7:0]  bv;
        logic [15:0] hv;
        idx = int'(r.alu_out[31:2]);
        shift = 8 * int'(r.alu_out[1:0]);
        word = shadow_mem[idx];
        bv = 8'(word >> shift);
        hv = 16'(word >> shift);
        value = '0;
        if (r.mem_signal.MemWrite) begin
            case (r.mem_signal.store_ops)
                sb_mem:  word = (word & ~(32'hff << shift)) | ((r.rs2_v & 32'hff) << shift);
                sh_mem:  word = (word & ~(32'hffff << shift)) | ((r.rs2_v & 32'hffff) << shift);
                default: word = r.rs2_v;
            endcase
            shadow_mem[idx] = word;
        end else begin
            case (r.wb_signal.regf_m_sel)
                alu_out_wb:  value = r.alu_out;
                br_en_wb:    value = r.br_en;
                u_imm_wb:    value = r.u_imm;
                lb_wb:       value = {{24{bv[7]}}, bv};
                lbu_wb:      value = {24'b0, bv};
                lh_wb:       value = {{16{hv[15]}}, hv};
                lhu_wb:      value = {16'b0, hv};
                lw_wb:       value = word;
                default:     value = r.pc + 32'd4;
            endcase
            if (r.wb_signal.regf_we && r.rd_s != 5'd0) begin
                shadow_regs[r.rd_s] = value;
            end
        end
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_regs();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            rs_s <= 5'(i);
            @(negedge clk);
            check_word($sformatf("rs_v[x%0d]", i), shadow_regs[i], rs_v);
        end
    endtask

    // Credits come back and records retire one per cycle at most.
    always @(negedge clk) begin
        if (rst_n) begin
            if (credit_return) begin
                ret_total++;
            end
            if (wb_commit) begin
                commits++;
            end
        end
    end

    initial begin
        int  sent;
        int  credits;
        int  waited;
        int  burst_start;
        bit  zero_seen;
        bit  stalled;
        sent = 0;
        waited = 0;
        burst_start = 0;
        zero_seen = 1'b0;
        stalled = 1'b0;
        rst_n = 1'b0;
        ex_valid = 1'b0;
        ex_in = '0;
        rs_s = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_word("credit_return", 32'd0, {31'b0, credit_return});
        check_word("wb_commit", 32'd0, {31'b0, wb_commit});
        compare_regs();

        // Known words first so every later load reads defined data.
        for (int i = 0; i < 16; i++) begin
            stim.push_back(make_record(4));
            stim[i].mem_signal.store_ops = sw_mem;
            stim[i].alu_out = 32'(i) << 2;
            predict_record(stim[i]);
        end
        repeat (200) begin
            stim.push_back(make_record(int'(rand_bits(3))));
            predict_record(stim[stim.size() - 1]);
        end
        // Load burst to drain the sender's credits.
        burst_start = stim.size();
        repeat (12) begin
            stim.push_back(make_record(7));
            predict_record(stim[stim.size() - 1]);
        end

        while (sent < stim.size() && waited < SEND_LIMIT) begin
            @(posedge clk);
            waited++;
            credits = `INGRESS_DEPTH - sent + ret_total;
            if (credits > 0) begin
                ex_valid <= 1'b1;
                ex_in <= stim[sent];
                sent++;
                if (credits == 1 && sent > burst_start) begin
                    zero_seen = 1'b1;
                end
            end else begin
                ex_valid <= 1'b0;
            end
        end
        @(posedge clk);
        ex_valid <= 1'b0;
        if (sent < stim.size()) begin
            failures++;
            stalled = 1'b1;
            $display("Timeout: only %0d of %0d records were sent", sent, stim.size());
        end

        if (!stalled) begin
            waited = 0;
            while (commits < sent && waited < DRAIN_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (commits < sent) begin
                failures++;
                $display("Timeout: %0d of %0d records committed", commits, sent);
            end else begin
                compare_regs();
                check_count("credit_return pulses", sent, ret_total);
                check_count("wb_commit pulses", sent, commits);
                if (!zero_seen) begin
                    failures++;
                    $display("The sender never ran out of credits during the load burst");
                end
            end
        end

        $display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
source/rv32i_types.sv
source/ingress_fifo.sv
source/mem_stage.sv
source/dmem_sram.sv
source/wb_stage.sv
source/regfile.sv
source/mem_wb_top.sv
dv/tb_mem_wb_top.sv

// File: Bender.yml
package:
  name: mem_wb_top

sources:
  - include_dirs:
      - include
    files:
      - source/rv32i_types.sv
      - source/ingress_fifo.sv
      - source/mem_stage.sv
      - source/dmem_sram.sv
      - source/wb_stage.sv
      - source/regfile.sv
      - source/mem_wb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_mem_wb_top.sv
